// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_arcade_io
FLIST     := flist.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== arcade_defs.svh ====
`ifndef ARCADE_DEFS_SVH
`define ARCADE_DEFS_SVH

// ######################################################################
// Download stream
// ######################################################################

`define LOAD_ADDR_W   16    // Byte address width of the loader
`define IDX_ROM       0     // Program ROM image
`define IDX_GAME      1     // Game type byte
`define IDX_DIP       254   // DIP switch block

// ######################################################################
// Program ROM layout
// ######################################################################

`define ROM_BANKS     6     // All banks the same size
`define BANK_WORD_W   10    // 1024 words per bank
`define PROG_ADDR_W   13    // Top three bits pick the bank

// Game types
`define GAME_DEFAULT  104   // Standard four player board
`define GAME_TANK     118   // Tank control variant

`define DIP_BYTES     8

`endif

// ==== arcade_ifs.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

// Byte stream from the loader, one byte per wr strobe
interface ioctl_if import arcade_pkg::*; ();
	logic       download;   // High for the whole transfer
	logic       wr;         // One cycle per byte
	byte_t      index;      // Which image is being sent
	load_addr_t addr;
	byte_t      dout;

	modport source (output download, wr, index, addr, dout);
	modport sink   (input  download, wr, index, addr, dout);
endinterface

// Word write port into the program ROM
interface rom_wr_if import arcade_pkg::*; ();
	logic       we;         // Single cycle pulse
	bank_sel_t  bank;
	bank_addr_t addr;
	word_t      data;

	modport source (output we, bank, addr, data);
	modport sink   (input  we, bank, addr, data);
endinterface

// ==== arcade_io_top.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

module arcade_io_top import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_download,   // Loader stream
	input  logic       dl_wr,
	input  byte_t      dl_index,
	input  load_addr_t dl_addr,
	input  byte_t      dl_dout,
	input  prog_addr_t prog_addr,     // CPU program fetch
	output word_t      prog_data,
	input  key_code_t  key_code,      // Keyboard events
	input  logic       key_pressed,
	input  logic       key_toggle,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  joy_t       joy2,
	input  joy_t       joy3,
	input  logic       service,
	output game_type_t game_type,
	output byte_t      dip_switches [`DIP_BYTES],
	output player_t    p1_n,
	output player_t    p2_n,
	output player_t    p3_n,
	output player_t    p4_n,
	output logic [4:0] sys_n
);

	ioctl_if  load_bus ();
	rom_wr_if rom_bus ();

	// Stream ports onto the bus
	assign load_bus.download = dl_download;
	assign load_bus.wr       = dl_wr;
	assign load_bus.index    = dl_index;
	assign load_bus.addr     = dl_addr;
	assign load_bus.dout     = dl_dout;

	download_decoder u_decoder (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load         (load_bus.sink),
		.rom_wr       (rom_bus.source),
		.game_type    (game_type),
		.dip_switches (dip_switches)
	);

	program_rom u_rom (
		.clk_sys   (clk_sys),
		.wr        (rom_bus.sink),
		.prog_addr (prog_addr),
		.prog_data (prog_data)
	);

	// Mapping follows the loaded game type
	player_inputs u_inputs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.key_toggle  (key_toggle),
		.joy0        (joy0),
		.joy1        (joy1),
		.joy2        (joy2),
		.joy3        (joy3),
		.service     (service),
		.game_type   (game_type),
		.p1_n        (p1_n),
		.p2_n        (p2_n),
		.p3_n        (p3_n),
		.p4_n        (p4_n),
		.sys_n       (sys_n)
	);

endmodule

// ==== arcade_pkg.sv ====
`include "arcade_defs.svh"

package arcade_pkg;

	// Plain data
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;        // Big endian pair from the loader

	// Download side
	typedef logic [`LOAD_ADDR_W-1:0] load_addr_t;

	// CPU side of the program ROM
	typedef logic [`PROG_ADDR_W-1:0] prog_addr_t;
	typedef logic [`PROG_ADDR_W-`BANK_WORD_W-1:0] bank_sel_t;  // Bank number
	typedef logic [`BANK_WORD_W-1:0] bank_addr_t;               // Word inside a bank

	// Inputs
	typedef logic [15:0] joy_t;         // 3..0 udlr, 7..4 buttons, 8 coin, 9 start
	typedef logic [8:0]  key_code_t;    // Extended flag on top of the scan code

	// Board side ports
	typedef logic [7:0]  player_t;      // Active low at the board
	typedef logic [7:0]  game_type_t;

endpackage

// ==== download_decoder.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

module download_decoder import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	ioctl_if.sink      load,                         // Loader byte stream
	rom_wr_if.source   rom_wr,                       // Word writes to program ROM
	output game_type_t game_type,
	output byte_t      dip_switches [`DIP_BYTES]
);

	localparam int BANK_LSB = `BANK_WORD_W + 1;     // Bank field sits above word address

	logic  load_hit;     // Valid byte this cycle
	logic  rom_hit;
	logic  dip_hit;
	logic  word_done;    // Second byte of a pair
	logic  bank_ok;
	byte_t acc_byte;     // Previous byte, high half of the word

	// ######################################################################
	// Strobe decode
	// ######################################################################

	assign load_hit  = load.download && load.wr;    // Ignore stray strobes
	assign rom_hit   = load_hit && (load.index == byte_t'(`IDX_ROM));
	assign word_done = rom_hit && load.addr[0];     // Odd address closes the pair

	// Only the first eight addresses of the DIP image land in registers
	assign dip_hit = load_hit && (load.index == byte_t'(`IDX_DIP))
		&& (load.addr[`LOAD_ADDR_W-1:3] == '0);

	// Banks above the last one are dropped
	assign bank_ok = int'(load.addr[`LOAD_ADDR_W-1:BANK_LSB]) < `ROM_BANKS;

	// Game type, default board after reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			game_type <= game_type_t'(`GAME_DEFAULT);
		else if (load_hit && load.index == byte_t'(`IDX_GAME))
			game_type <= load.dout;                 // Last byte sent wins
	end

	// DIP switch bytes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < `DIP_BYTES; i++)
				dip_switches[i] <= '0;
		end else if (dip_hit) begin
			dip_switches[load.addr[2:0]] <= load.dout;
		end
	end

	// ######################################################################
	// Word assembly
	// ######################################################################

	// Every ROM byte shifts in, odd one uses the old value below
	always_ff @(posedge clk_sys) begin
		if (rom_hit)
			acc_byte <= load.dout;
	end

	// Write pulse
	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_wr.we <= 1'b0;
		else
			rom_wr.we <= word_done && bank_ok;      // One cycle per pair
	end

	// Write payload, held until the next pair
	always_ff @(posedge clk_sys) begin
		if (word_done) begin
			rom_wr.bank <= load.addr[BANK_LSB+2:BANK_LSB];
			rom_wr.addr <= load.addr[`BANK_WORD_W:1];   // Byte to word address
			rom_wr.data <= {acc_byte, load.dout};       // First byte is high
		end
	end

	// A ROM write only follows a byte taken during a download
	a_we_after_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr.we |-> $past(load.download));

endmodule

// ==== flist.f ====
+incdir+.
arcade_pkg.sv
arcade_ifs.sv
download_decoder.sv
program_rom.sv
player_inputs.sv
arcade_io_top.sv
tb_clock.sv
tb_arcade_io.sv

// ==== player_inputs.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

module player_inputs import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  key_code_t  key_code,
	input  logic       key_pressed,
	input  logic       key_toggle,    // Flips once per key event
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  joy_t       joy2,
	input  joy_t       joy3,
	input  logic       service,
	input  game_type_t game_type,
	output player_t    p1_n,
	output player_t    p2_n,
	output player_t    p3_n,
	output player_t    p4_n,
	output logic [4:0] sys_n          // Service, then coins 1 to 4
);

	logic       toggle_q;
	logic       tank_mode;
	player_t    p1_k, p2_k, p3_k, p4_k;  // Key latches, active high
	logic [3:0] coin_k;
	logic [3:0] tread0_q;                // {r_back, l_back, r_fwd, l_fwd}
	logic [3:0] tread1_q;

	assign tank_mode = (game_type == game_type_t'(`GAME_TANK));

	// Eight direction stick to two treads, input is {up, down, left, right}
	function automatic logic [3:0] tread_map(input logic [3:0] udlr);
		case (udlr)
			4'b1010: tread_map = 4'b0010;   // Up left, right tread only
			4'b1000: tread_map = 4'b0011;   // Up
			4'b1001: tread_map = 4'b0001;   // Up right, left tread only
			4'b0001: tread_map = 4'b1001;   // Right, spin
			4'b0101: tread_map = 4'b0100;   // Down right
			4'b0100: tread_map = 4'b1100;   // Down
			4'b0110: tread_map = 4'b1000;   // Down left
			4'b0010: tread_map = 4'b0110;   // Left, spin
			default: tread_map = 4'b0000;
		endcase
	endfunction

	// ######################################################################
	// Keyboard latches
	// ######################################################################

	always_ff @(posedge clk_sys) begin
		toggle_q <= key_toggle;         // Edge detect runs through reset
		if (reset) begin
			p1_k   <= '0;
			p2_k   <= '0;
			p3_k   <= '0;
			p4_k   <= '0;
			coin_k <= '0;
		end else if (toggle_q != key_toggle) begin
			if (tank_mode) begin
				// Treads on the low nibble, thumbs and triggers above
				case (key_code)
					9'h023: p1_k[3]   <= key_pressed; // P1 right back  (D)
					9'h01B: p1_k[2]   <= key_pressed; // P1 left back   (S)
					9'h024: p1_k[1]   <= key_pressed; // P1 right fwd   (E)
					9'h01D: p1_k[0]   <= key_pressed; // P1 left fwd    (W)
					9'h02D: p1_k[7]   <= key_pressed; // P1 right thumb (R)
					9'h015: p1_k[6]   <= key_pressed; // P1 left thumb  (Q)
					9'h02B: p1_k[5]   <= key_pressed; // P1 right trig  (F)
					9'h01C: p1_k[4]   <= key_pressed; // P1 left trig   (A)
					9'h042: p2_k[3]   <= key_pressed; // P2 right back  (K)
					9'h03B: p2_k[2]   <= key_pressed; // P2 left back   (J)
					9'h043: p2_k[1]   <= key_pressed; // P2 right fwd   (I)
					9'h03C: p2_k[0]   <= key_pressed; // P2 left fwd    (U)
					9'h044: p2_k[7]   <= key_pressed; // P2 right thumb (O)
					9'h035: p2_k[6]   <= key_pressed; // P2 left thumb  (Y)
					9'h04B: p2_k[5]   <= key_pressed; // P2 right trig  (L)
					9'h033: p2_k[4]   <= key_pressed; // P2 left trig   (H)
					9'h016: p3_k[0]   <= key_pressed; // P1 start (1)
					9'h01E: p3_k[1]   <= key_pressed; // P2 start (2)
					9'h02E: coin_k[0] <= key_pressed; // Coin 1 (5)
					9'h036: coin_k[1] <= key_pressed; // Coin 2 (6)
					default: ;
				endcase
			end else begin
				case (key_code)
					9'h175: p1_k[7]   <= key_pressed; // Up arrow
					9'h172: p1_k[6]   <= key_pressed; // Down arrow
					9'h16B: p1_k[5]   <= key_pressed; // Left arrow
					9'h174: p1_k[4]   <= key_pressed; // Right arrow
					9'h014: p1_k[1]   <= key_pressed; // Fire, left ctrl
					9'h011: p1_k[0]   <= key_pressed; // Magic, left alt
					9'h02D: p2_k[7]   <= key_pressed; // R
					9'h02B: p2_k[6]   <= key_pressed; // F
					9'h023: p2_k[5]   <= key_pressed; // D
					9'h034: p2_k[4]   <= key_pressed; // G
					9'h01C: p2_k[1]   <= key_pressed; // A
					9'h01B: p2_k[0]   <= key_pressed; // S
					9'h043: p3_k[7]   <= key_pressed; // I
					9'h042: p3_k[6]   <= key_pressed; // K
					9'h03B: p3_k[5]   <= key_pressed; // J
					9'h04B: p3_k[4]   <= key_pressed; // L
					9'h114: p3_k[1]   <= key_pressed; // Right ctrl
					9'h059: p3_k[0]   <= key_pressed; // Right shift
					9'h075: p4_k[7]   <= key_pressed; // Keypad 8
					9'h072: p4_k[6]   <= key_pressed; // Keypad 2
					9'h06B: p4_k[5]   <= key_pressed; // Keypad 4
					9'h074: p4_k[4]   <= key_pressed; // Keypad 6
					9'h070: p4_k[1]   <= key_pressed; // Keypad 0
					9'h071: p4_k[0]   <= key_pressed; // Keypad dot
					9'h02E: coin_k[0] <= key_pressed; // Coins on 5 to 8
					9'h036: coin_k[1] <= key_pressed;
					9'h03D: coin_k[2] <= key_pressed;
					9'h03E: coin_k[3] <= key_pressed;
					default: ;
				endcase
			end
		end
	end

	// Tank translation, one register stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tread0_q <= '0;
			tread1_q <= '0;
		end else begin
			tread0_q <= tread_map(joy0[3:0]);
			tread1_q <= tread_map(joy1[3:0]);
		end
	end

	// ######################################################################
	// Port composition
	// ######################################################################

	always_comb begin
		if (tank_mode) begin
			p1_n = ~(p1_k | {joy0[7:4], tread0_q});
			p2_n = ~(p2_k | {joy1[7:4], tread1_q});
			p3_n = ~(p3_k | {6'b0, joy1[9], joy0[9]});  // Start buttons
			p4_n = ~p4_k;
		end else begin
			p1_n = ~(p1_k | {joy0[3:0], joy0[7:4]});    // Stick high, buttons low
			p2_n = ~(p2_k | {joy1[3:0], joy1[7:4]});
			p3_n = ~(p3_k | {joy2[3:0], joy2[7:4]});
			p4_n = ~(p4_k | {joy3[3:0], joy3[7:4]});
		end
	end

	assign sys_n = {~service,
		~(coin_k[0] | joy0[8]), ~(coin_k[1] | joy1[8]),
		~(coin_k[2] | joy2[8]), ~(coin_k[3] | joy3[8])};

endmodule

// ==== program_rom.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

module program_rom import arcade_pkg::*; (
	input  logic       clk_sys,
	rom_wr_if.sink     wr,          // From the download decoder
	input  prog_addr_t prog_addr,   // CPU word address
	output word_t      prog_data    // One cycle after prog_addr
);

	localparam int BANK_WORDS = 1 << `BANK_WORD_W;

	bank_addr_t rd_addr;
	bank_sel_t  rd_bank;
	bank_sel_t  sel_q;                  // Bank of the word now on bank_q
	word_t      bank_q [`ROM_BANKS];    // Read data of every bank

	assign rd_addr = prog_addr[`BANK_WORD_W-1:0];
	assign rd_bank = prog_addr[`PROG_ADDR_W-1:`BANK_WORD_W];

	// ######################################################################
	// Bank storage
	// ######################################################################

	// All banks read the same word each cycle, select comes after
	generate
		for (genvar b = 0; b < `ROM_BANKS; b++) begin : g_bank
			word_t mem [BANK_WORDS];

			always_ff @(posedge clk_sys) begin
				if (wr.we && wr.bank == bank_sel_t'(b))
					mem[wr.addr] <= wr.data;
				bank_q[b] <= mem[rd_addr];      // Synchronous read
			end
		end
	endgenerate

	// Select travels with the read
	always_ff @(posedge clk_sys) begin
		sel_q <= rd_bank;
	end

	// ######################################################################
	// Output mux
	// ######################################################################

	// Selects 6 and 7 match nothing and read as zero
	always_comb begin
		prog_data = '0;
		for (int i = 0; i < `ROM_BANKS; i++) begin
			if (sel_q == bank_sel_t'(i))
				prog_data = bank_q[i];
		end
	end

	// Decoder drops unmapped banks before they reach this port
	a_bank_mapped: assert property (@(posedge clk_sys)
		wr.we |-> (int'(wr.bank) < `ROM_BANKS));

endmodule

// ==== tb_arcade_io.sv ====
`timescale 1ns/1ps
`include "arcade_defs.svh"

module tb_arcade_io import arcade_pkg::*; ();

	logic       clk_sys;
	logic       reset;
	logic       dl_download;
	logic       dl_wr;
	byte_t      dl_index;
	load_addr_t dl_addr;
	byte_t      dl_dout;
	prog_addr_t prog_addr;
	word_t      prog_data;
	key_code_t  key_code;
	logic       key_pressed;
	logic       key_toggle;
	joy_t       joy0;
	joy_t       joy1;
	joy_t       joy2;
	joy_t       joy3;
	logic       service;
	game_type_t game_type;
	byte_t      dip_switches [`DIP_BYTES];
	player_t    p1_n;
	player_t    p2_n;
	player_t    p3_n;
	player_t    p4_n;
	logic [4:0] sys_n;

	int    seed = 32'h6d87;
	int    checks = 0;
	int    errors = 0;
	int    mark_checks = 0;     // Counts at the start of the current test
	int    mark_errors = 0;
	word_t rom_model [`ROM_BANKS << `BANK_WORD_W];   // Expected words by bank then word
	byte_t dip_model [`DIP_BYTES];

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	arcade_io_top dut0 (
		.clk_sys(clk_sys), .reset(reset),
		.dl_download(dl_download), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_dout(dl_dout),
		.prog_addr(prog_addr), .prog_data(prog_data),
		.key_code(key_code), .key_pressed(key_pressed), .key_toggle(key_toggle),
		.joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3), .service(service),
		.game_type(game_type), .dip_switches(dip_switches),
		.p1_n(p1_n), .p2_n(p2_n), .p3_n(p3_n), .p4_n(p4_n), .sys_n(sys_n)
	);

	// Service switch shows inverted on sys_n bit 4
	a_service: assert property (@(posedge clk_sys) disable iff (reset) sys_n[4] == !service)
	else begin
		$display("FAIL sys_n[4] expected %0b actual %0b", !service, sys_n[4]);
		errors++;
	end

	// ######################################################################
	// Helpers
	// ######################################################################

	task automatic step();
		@(posedge clk_sys);
		#1;                         // Inputs move just after the edge
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic test_done(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic wait_reset_release(output logic ok);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (reset && n < 100);   // Gives up after 100 edges
		#1;
		ok = !reset;
	endtask

	// One byte per edge and wr dropped afterwards
	task automatic send_byte(input byte_t idx, input load_addr_t addr, input byte_t data,
		input logic dl);
		dl_download = dl;
		dl_wr       = 1'b1;
		dl_index    = idx;
		dl_addr     = addr;
		dl_dout     = data;
		step();
		dl_wr       = 1'b0;
	endtask

	task automatic send_key(input key_code_t code, input logic pressed);
		key_code    = code;
		key_pressed = pressed;
		key_toggle  = ~key_toggle;  // Event marker
		repeat (2) step();          // Latch then ports settle
	endtask

	task automatic read_word(input string name, input prog_addr_t addr, input word_t exp);
		prog_addr = addr;
		step();                     // One cycle read latency
		check(name, 32'(exp), 32'(prog_data));
	endtask

	// ######################################################################
	// Tests
	// ######################################################################

	initial begin
		byte_t hi;
		byte_t lo;
		logic  reset_ok;
		dl_download = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_dout     = '0;
		prog_addr   = '0;
		key_code    = '0;
		key_pressed = 1'b0;
		key_toggle  = 1'b0;
		joy0        = '0;
		joy1        = '0;
		joy2        = '0;
		joy3        = '0;
		service     = 1'b0;
		wait_reset_release(reset_ok);
		if (reset_ok) begin
			// Reset values then DIP and game type loads
			check("reset game_type", 32'(`GAME_DEFAULT), 32'(game_type));
			for (int i = 0; i < `DIP_BYTES; i++)
				check($sformatf("reset dip %0d", i), 32'h0, 32'(dip_switches[i]));
			check("reset p1_n", 32'hff, 32'(p1_n));
			check("reset p2_n", 32'hff, 32'(p2_n));
			check("reset p3_n", 32'hff, 32'(p3_n));
			check("reset p4_n", 32'hff, 32'(p4_n));
			check("reset sys_n", 32'h1f, 32'(sys_n));   // Service off, no coins
			for (int i = 0; i < `DIP_BYTES; i++) begin
				dip_model[i] = byte_t'($random(seed));
				send_byte(byte_t'(`IDX_DIP), load_addr_t'(i), dip_model[i], 1'b1);
			end
			send_byte(byte_t'(`IDX_GAME), 16'h0000, 8'd106, 1'b1);
			dl_download = 1'b0;
			step();
			for (int i = 0; i < `DIP_BYTES; i++)
				check($sformatf("dip %0d", i), 32'(dip_model[i]), 32'(dip_switches[i]));
			check("game_type 106", 32'd106, 32'(game_type));
			test_done("reset_dip_game");

			// Full image in big endian pairs
			for (int b = 0; b < `ROM_BANKS; b++) begin
				for (int w = 0; w < (1 << `BANK_WORD_W); w++) begin
					hi = byte_t'($random(seed));
					lo = byte_t'($random(seed));
					send_byte(byte_t'(`IDX_ROM), load_addr_t'((b << 11) | (w << 1)), hi, 1'b1);
					send_byte(byte_t'(`IDX_ROM), load_addr_t'((b << 11) | (w << 1) | 1), lo,
						1'b1);
					rom_model[(b << 10) | w] = {hi, lo};
				end
			end
			dl_download = 1'b0;
			repeat (2) step();      // Last pulse lands in memory
			for (int b = 0; b < `ROM_BANKS; b++)
				for (int w = 0; w < (1 << `BANK_WORD_W); w += 10)
					read_word($sformatf("rom bank %0d word %0d", b, w),
						prog_addr_t'((b << 10) | w), rom_model[(b << 10) | w]);
			test_done("rom_load");

			// Unmapped banks and bytes that must not reach the ROM
			for (int w = 0; w < 40; w += 10) begin
				read_word("bank 6 read", prog_addr_t'((6 << 10) | w), 16'h0000);
				read_word("bank 7 read", prog_addr_t'((7 << 10) | w), 16'h0000);
			end
			send_byte(byte_t'(`IDX_GAME), 16'h0010, 8'd106, 1'b1);
			send_byte(byte_t'(`IDX_GAME), 16'h0011, 8'd106, 1'b1);
			send_byte(byte_t'(`IDX_DIP), 16'h0010, 8'h5a, 1'b1);   // Above the DIP block
			send_byte(byte_t'(`IDX_DIP), 16'h0011, 8'ha5, 1'b1);
			send_byte(byte_t'(`IDX_GAME), 16'h0000, 8'd77, 1'b0);  // Download low
			send_byte(byte_t'(`IDX_ROM), 16'h0010, 8'hde, 1'b0);
			send_byte(byte_t'(`IDX_ROM), 16'h0011, 8'had, 1'b0);
			dl_download = 1'b0;
			repeat (2) step();
			read_word("rom word 8 kept", 13'd8, rom_model[8]);
			check("game_type kept", 32'd106, 32'(game_type));
			for (int i = 0; i < `DIP_BYTES; i++)
				check($sformatf("dip %0d kept", i), 32'(dip_model[i]), 32'(dip_switches[i]));
			test_done("rom_protect");

			// Standard four player mapping
			send_key(9'h175, 1'b1);
			check("up arrow pressed", 32'h7f, 32'(p1_n));
			send_key(9'h175, 1'b0);
			check("up arrow released", 32'hff, 32'(p1_n));
			joy2 = 16'h0008;        // Stick up
			repeat (2) step();
			check("joy2 up", 32'h7f, 32'(p3_n));
			joy2 = '0;
			joy1 = 16'h0100;        // Coin button
			repeat (2) step();
			check("joy1 coin", 32'h1b, 32'(sys_n));
			joy1    = '0;
			service = 1'b1;
			repeat (2) step();
			check("service on", 32'h0f, 32'(sys_n));
			service = 1'b0;
			step();
			test_done("standard_inputs");

			// Tank variant with treads as {r_back, l_back, r_fwd, l_fwd}
			send_byte(byte_t'(`IDX_GAME), 16'h0000, byte_t'(`GAME_TANK), 1'b1);
			dl_download = 1'b0;
			step();
			check("game_type tank", 32'(`GAME_TANK), 32'(game_type));
			joy0 = 16'h0008;
			repeat (2) step();
			check("tank up", 32'hfc, 32'(p1_n));       // Both forward
			joy0 = 16'h0002;
			repeat (2) step();
			check("tank left", 32'hf9, 32'(p1_n));     // Left back and right forward
			joy0 = '0;
			send_key(9'h016, 1'b1);
			check("tank start 1", 32'hfe, 32'(p3_n));
			send_key(9'h016, 1'b0);
			check("tank start 1 off", 32'hff, 32'(p3_n));
			test_done("tank_inputs");
		end else begin
			$display("reset stayed high past its timeout");
		end
		$display("total: %0d checks, %0d errors", checks, errors);
		if (reset_ok && errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// 10 ns period
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Held for 16 rising edges, dropped just after the last one
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule
